//--- Bender.yml
package:
  name: lsu

sources:
  - verilog/lsuPkg.sv
  - verilog/lsuIf.sv
  - verilog/lsuDecode.sv
  - verilog/lsuExecute.sv
  - verilog/lsuResult.sv
  - verilog/lsuTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/lsuTb_assert.sv
      - tests/lsuTb.sv

//--- build.f
+incdir+verilog
verilog/lsuPkg.sv
verilog/lsuIf.sv
verilog/lsuDecode.sv
verilog/lsuExecute.sv
verilog/lsuResult.sv
verilog/lsuTop.sv
tests/clockGen.sv
tests/lsuTb_assert.sv
tests/lsuTb.sv

//--- tests/clockGen.sv
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic rst
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset spans two rising edges and is released just after the second
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
  end

endmodule

//--- tests/lsuTb.sv
`timescale 1ns/100ps

module lsuTb;

  localparam int numOps = 16;
  localparam int timeoutCycles = 40 * numOps;

  logic clk, rst, opReq, opAck, opIsStore, memReq, memAck, memWrite, resValid;
  lsuPkg::addrT opAddr, memAddr, resAddr, lastRdAddr, lastWrAddr;
  lsuPkg::wordT opWdata, memWdata, memRdata, resData;
  lsuPkg::byteMaskT opMask;
  lsuPkg::wordT mem [lsuPkg::addrT];
  lsuPkg::wordT refMem [lsuPkg::addrT];
  int errCount = 0;
  int cycles = 0;
  int reqCount = 0;
  int rdCount = 0;
  int wrCount = 0;
  int opReqs;

  clockGen clockGen_i (.clk(clk), .rst(rst));
  lsuTop lsuTop_i (.*);

  function automatic lsuPkg::wordT memWord(lsuPkg::addrT addr);
    // untouched memory holds a random word drawn on first use
    if (!mem.exists(addr)) mem[addr] = $urandom;
    return mem[addr];
  endfunction

  function automatic lsuPkg::wordT refWord(lsuPkg::addrT addr);
    if (!refMem.exists(addr)) refMem[addr] = memWord(addr);
    return refMem[addr];
  endfunction

  function automatic lsuPkg::wordT applyStore(lsuPkg::wordT oldWord, lsuPkg::wordT newWord,
                                              lsuPkg::byteMaskT mask);
    lsuPkg::wordT laneBits;
    laneBits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (oldWord & ~laneBits) | (newWord & laneBits);
  endfunction

  task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errCount++;
    $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
  endtask

  task automatic printCounts();
    $display("errors: value checks %0d, handshake assertions %0d",
             errCount, lsuTop_i.handshakeChk_i.failCount);
  endtask

  // one op through the four-phase port, checked against the reference model
  task automatic runOp(logic isStore, lsuPkg::addrT addr, lsuPkg::wordT wdata,
                       lsuPkg::byteMaskT mask);
    lsuPkg::wordT expected;
    int reqBefore;
    reqBefore = reqCount;
    if (isStore) refMem[addr] = applyStore(refWord(addr), wdata, mask);
    expected = refWord(addr);
    @(posedge clk);
    #10;
    opIsStore = isStore;
    opAddr = addr;
    opWdata = wdata;
    opMask = mask;
    opReq = 1'b1;
    do @(negedge clk); while (!opAck);
    @(posedge clk);
    #10;
    opReq = 1'b0;
    do @(negedge clk); while (!resValid);
    opReqs = reqCount - reqBefore;
    assert (resAddr === addr) else reportMismatch("resAddr", addr, resAddr);
    assert (resData === expected) else reportMismatch("resData", expected, resData);
    while (opAck) @(negedge clk);
  endtask

  // memory slave, answers after 1 to 3 cycles
  always begin
    @(negedge clk);
    if (memReq && !rst) begin
      reqCount++;
      repeat ($urandom_range(1, 3)) @(posedge clk);
      #10;
      if (memWrite) begin
        assert (memWdata === refWord(memAddr))
          else reportMismatch("memWdata", refWord(memAddr), memWdata);
        mem[memAddr] = memWdata;
        lastWrAddr = memAddr;
        wrCount++;
      end else begin
        memRdata = memWord(memAddr);
        lastRdAddr = memAddr;
        rdCount++;
      end
      memAck = 1'b1;
      do @(negedge clk); while (memReq);
      @(posedge clk);
      #10;
      memAck = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("timeout: no end of the run after %0d cycles", timeoutCycles);
      printCounts();
      $display("test failed");
      $finish;
    end
  end

  initial begin
    int rdBefore;
    int wrBefore;
    void'($urandom(51608));
    opReq = 1'b0;
    opIsStore = 1'b0;
    opAddr = '0;
    opWdata = '0;
    opMask = '0;
    memAck = 1'b0;
    memRdata = '0;
    do @(negedge clk); while (rst);

    // cold load goes to memory at its own address
    rdBefore = rdCount;
    runOp(1'b0, 32'h0000_0104, '0, '0);
    assert (rdCount > rdBefore) else begin
      errCount++;
      $display("load miss issued no memory read");
    end
    assert (lastRdAddr === 32'h0000_0104) else reportMismatch("memAddr", 32'h104, lastRdAddr);

    // same load again must hit
    runOp(1'b0, 32'h0000_0104, '0, '0);
    assert (opReqs == 0) else begin
      errCount++;
      $display("repeated load went to memory instead of hitting");
    end

    runOp(1'b1, 32'h0000_0104, 32'ha5c3_1e77, 4'b0101);
    runOp(1'b0, 32'h0000_0104, '0, '0);

    // three lines of set 5, the dirty one gets evicted
    wrBefore = wrCount;
    runOp(1'b1, 32'h0000_0214, 32'h1234_5678, 4'b1100);
    runOp(1'b0, 32'h0000_0234, '0, '0);
    runOp(1'b0, 32'h0000_0254, '0, '0);
    assert (wrCount > wrBefore) else begin
      errCount++;
      $display("dirty line was never written back");
    end
    assert (lastWrAddr === 32'h0000_0214) else reportMismatch("memAddr", 32'h214, lastWrAddr);
    runOp(1'b0, 32'h0000_0214, '0, '0);

    // random mix over a small range for set conflicts
    for (int i = 0; i < 8; i++) begin
      runOp(1'($urandom_range(0, 1)), lsuPkg::addrT'($urandom_range(0, 63) << 2), $urandom,
            lsuPkg::byteMaskT'($urandom_range(1, 15)));
    end

    repeat (2) @(negedge clk);
    printCounts();
    if (errCount == 0 && lsuTop_i.handshakeChk_i.failCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- tests/lsuTb_assert.sv
`timescale 1ns/100ps

module lsuTb_assert (
  input logic clk,
  input logic rst,
  input logic opReq,
  input logic opAck,
  input logic memReq,
  input logic memAck,
  input logic memWrite,
  input lsuPkg::addrT memAddr,
  input lsuPkg::wordT memWdata,
  input logic resValid
);

  int failCount = 0;
  logic inFlight;

  // an op is in flight from its acknowledge until its result
  always_ff @(posedge clk) begin
    if (rst) begin
      inFlight <= 1'b0;
    end else if (resValid) begin
      inFlight <= 1'b0;
    end else if (opAck) begin
      inFlight <= 1'b1;
    end
  end

  resetQuiet: assert property (@(posedge clk) rst |=> !opAck && !memReq && !resValid)
    else begin failCount++; $error("outputs active after reset"); end

  memHold: assert property (@(posedge clk) disable iff (rst) memReq && !memAck |=> memReq)
    else begin failCount++; $error("memReq dropped before memAck"); end

  memStable: assert property (@(posedge clk) disable iff (rst)
    memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWrite)
      && (!memWrite || $stable(memWdata)))
    else begin failCount++; $error("memory request fields changed while memReq high"); end

  ackRelease: assert property (@(posedge clk) disable iff (rst) opAck && opReq |=> opAck)
    else begin failCount++; $error("opAck fell while opReq still high"); end

  resPulse: assert property (@(posedge clk) disable iff (rst) resValid |=> !resValid)
    else begin failCount++; $error("resValid longer than one cycle"); end

  resOwned: assert property (@(posedge clk) disable iff (rst) resValid |-> inFlight)
    else begin failCount++; $error("resValid without an accepted op"); end

endmodule

bind lsuTop lsuTb_assert handshakeChk_i (.*);

//--- verilog/lsuDecode.sv
`timescale 1ns/100ps

module lsuDecode (
  input logic clk,
  input logic rst,
  input logic opReq,
  output logic opAck,
  input logic opIsStore,
  input lsuPkg::addrT opAddr,
  input lsuPkg::wordT opWdata,
  input lsuPkg::byteMaskT opMask,
  opIf.decodeSide op
);

  logic accept;

  // only one op in flight, so nothing is taken while one is held
  assign accept = opReq && !opAck && !op.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      opAck <= 1'b0;
      op.valid <= 1'b0;
    end else begin
      if (accept) begin
        opAck <= 1'b1;
        op.valid <= 1'b1;
      end else if (opAck && !opReq) begin
        // host released its request
        opAck <= 1'b0;
      end
      if (op.done) begin
        op.valid <= 1'b0;
      end
    end
  end

  // holding registers for the op fields
  always_ff @(posedge clk) begin
    if (accept) begin
      op.isStore <= opIsStore;
      op.addr <= opAddr;
      op.wdata <= opWdata;
      op.mask <= opMask;
    end
  end

endmodule

//--- verilog/lsuExecute.sv
`timescale 1ns/100ps

module lsuExecute (
  input logic clk,
  input logic rst,
  opIf.executeSide op,
  lookupIf.executeSide look
);

  lsuPkg::tagT tagArr [lsuPkg::numSets][lsuPkg::numWays];
  lsuPkg::wordT dataArr [lsuPkg::numSets][lsuPkg::numWays];
  logic [lsuPkg::numWays-1:0] validArr [lsuPkg::numSets];
  logic [lsuPkg::numWays-1:0] dirtyArr [lsuPkg::numSets];
  lsuPkg::wayT replPtr [lsuPkg::numSets];

  lsuPkg::setIdxT setIdx;
  lsuPkg::tagT opTag;
  logic [lsuPkg::numWays-1:0] hitVec;
  lsuPkg::wayT hitEnc;
  lsuPkg::wayT vicWay;

  assign setIdx = op.addr[lsuPkg::idxW+1:2];
  assign opTag = op.addr[lsuPkg::addrW-1:lsuPkg::idxW+2];
  assign vicWay = replPtr[setIdx];

  // tag compare across all ways, then encode the one-hot hit
  always_comb begin
    hitEnc = '0;
    for (int w = 0; w < lsuPkg::numWays; w++) begin
      hitVec[w] = validArr[setIdx][w] && (tagArr[setIdx][w] == opTag);
      if (hitVec[w]) begin
        hitEnc = lsuPkg::wayT'(w);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      look.hit <= 1'b0;
      look.victimValid <= 1'b0;
      look.victimDirty <= 1'b0;
    end else if (op.valid) begin
      look.hit <= |hitVec;
      look.victimValid <= validArr[setIdx][vicWay];
      look.victimDirty <= dirtyArr[setIdx][vicWay];
    end
  end

  always_ff @(posedge clk) begin
    if (op.valid) begin
      look.hitWay <= hitEnc;
      look.rdata <= dataArr[setIdx][hitEnc];
      look.victimWay <= vicWay;
      look.victimTag <= tagArr[setIdx][vicWay];
      look.victimData <= dataArr[setIdx][vicWay];
    end
  end

  // line state and replacement pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < lsuPkg::numSets; s++) begin
        validArr[s] <= '0;
        dirtyArr[s] <= '0;
        replPtr[s] <= '0;
      end
    end else if (look.storeEn) begin
      dirtyArr[setIdx][look.hitWay] <= 1'b1;
      replPtr[setIdx] <= ~replPtr[setIdx];
    end else if (look.fillEn) begin
      validArr[setIdx][look.victimWay] <= 1'b1;
      dirtyArr[setIdx][look.victimWay] <= 1'b0;
      replPtr[setIdx] <= ~replPtr[setIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (look.storeEn) begin
      dataArr[setIdx][look.hitWay] <=
        lsuPkg::mergeWord(dataArr[setIdx][look.hitWay], op.wdata, op.mask);
    end else if (look.fillEn) begin
      dataArr[setIdx][look.victimWay] <= look.fillData;
      tagArr[setIdx][look.victimWay] <= opTag;
    end
  end

endmodule

//--- verilog/lsuIf.sv
`timescale 1ns/100ps

// the op held by lsuDecode until lsuResult retires it
interface opIf;
  logic valid;
  logic isStore;
  lsuPkg::addrT addr;
  lsuPkg::wordT wdata;
  lsuPkg::byteMaskT mask;
  logic done;

  modport decodeSide(output valid, isStore, addr, wdata, mask, input done);
  modport executeSide(input valid, addr, wdata, mask);
  modport resultSide(input valid, isStore, addr, wdata, mask, output done);
endinterface

// registered lookup results one way, write strobes the other
interface lookupIf;
  logic hit;
  lsuPkg::wayT hitWay;
  lsuPkg::wordT rdata;
  lsuPkg::wayT victimWay;
  logic victimValid;
  logic victimDirty;
  lsuPkg::tagT victimTag;
  lsuPkg::wordT victimData;
  logic fillEn;
  lsuPkg::wordT fillData;
  logic storeEn;

  modport executeSide(
    output hit, hitWay, rdata, victimWay, victimValid, victimDirty, victimTag, victimData,
    input fillEn, fillData, storeEn
  );
  modport resultSide(
    input hit, rdata, victimValid, victimDirty, victimTag, victimData,
    output fillEn, fillData, storeEn
  );
endinterface

//--- verilog/lsuPkg.sv
package lsuPkg;

  // cache geometry
  localparam int addrW = 32;
  localparam int dataW = 32;
  localparam int numWays = 2;
  localparam int numSets = 8;
  localparam int idxW = 3;
  localparam int tagW = addrW - idxW - 2;
  localparam int maskW = 4;

  typedef logic [addrW-1:0] addrT;
  typedef logic [dataW-1:0] wordT;
  typedef logic [tagW-1:0] tagT;
  typedef logic [idxW-1:0] setIdxT;
  typedef logic [$clog2(numWays)-1:0] wayT;
  typedef logic [maskW-1:0] byteMaskT;

  // miss handling sequence of lsuResult
  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stWbReq,
    stWbRel,
    stFillReq,
    stFillRel,
    stRetry
  } missStateT;

  // byte-lane merge of a store word into an existing word
  function automatic wordT mergeWord(wordT oldWord, wordT newWord, byteMaskT mask);
    wordT merged;
    merged = oldWord;
    for (int b = 0; b < maskW; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- verilog/lsuResult.sv
`timescale 1ns/100ps

module lsuResult (
  input logic clk,
  input logic rst,
  opIf.resultSide op,
  lookupIf.resultSide look,
  output logic memReq,
  input logic memAck,
  output logic memWrite,
  output lsuPkg::addrT memAddr,
  output lsuPkg::wordT memWdata,
  input lsuPkg::wordT memRdata,
  output logic resValid,
  output lsuPkg::addrT resAddr,
  output lsuPkg::wordT resData
);

  lsuPkg::missStateT state;
  lsuPkg::setIdxT setIdx;
  lsuPkg::wordT mergedWord;
  logic needWb;

  assign setIdx = op.addr[lsuPkg::idxW+1:2];
  assign mergedWord = lsuPkg::mergeWord(look.rdata, op.wdata, op.mask);
  // a valid dirty victim goes back to memory before the refill
  assign needWb = look.victimValid && look.victimDirty;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= lsuPkg::stIdle;
      memReq <= 1'b0;
      memWrite <= 1'b0;
      resValid <= 1'b0;
      op.done <= 1'b0;
      look.fillEn <= 1'b0;
      look.storeEn <= 1'b0;
    end else begin
      resValid <= 1'b0;
      op.done <= 1'b0;
      look.fillEn <= 1'b0;
      look.storeEn <= 1'b0;
      case (state)
        lsuPkg::stIdle: begin
          // done still high means the last op is only just retiring
          if (op.valid && !op.done) begin
            state <= lsuPkg::stLookup;
          end
        end
        lsuPkg::stLookup: begin
          memReq <= !look.hit;
          memWrite <= !look.hit && needWb;
          if (look.hit) begin
            resValid <= 1'b1;
            op.done <= 1'b1;
            look.storeEn <= op.isStore;
            state <= lsuPkg::stIdle;
          end else if (needWb) begin
            state <= lsuPkg::stWbReq;
          end else begin
            state <= lsuPkg::stFillReq;
          end
        end
        lsuPkg::stWbReq: begin
          if (memAck) begin
            memReq <= 1'b0;
            state <= lsuPkg::stWbRel;
          end
        end
        lsuPkg::stWbRel: begin
          if (!memAck) begin
            memReq <= 1'b1;
            memWrite <= 1'b0;
            state <= lsuPkg::stFillReq;
          end
        end
        lsuPkg::stFillReq: begin
          if (memAck) begin
            memReq <= 1'b0;
            look.fillEn <= 1'b1;
            state <= lsuPkg::stFillRel;
          end
        end
        lsuPkg::stFillRel: begin
          if (!memAck) begin
            state <= lsuPkg::stRetry;
          end
        end
        // one cycle for the filled line to reach the lookup registers
        lsuPkg::stRetry: state <= lsuPkg::stLookup;
        default: state <= lsuPkg::stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == lsuPkg::stLookup) begin
      if (look.hit) begin
        resAddr <= op.addr;
        resData <= op.isStore ? mergedWord : look.rdata;
      end else if (needWb) begin
        memAddr <= {look.victimTag, setIdx, 2'b00};
        memWdata <= look.victimData;
      end else begin
        memAddr <= op.addr;
      end
    end
    if (state == lsuPkg::stWbRel && !memAck) begin
      memAddr <= op.addr;
    end
    // read data is only valid while memAck is high
    if (state == lsuPkg::stFillReq && memAck) begin
      look.fillData <= memRdata;
    end
  end

endmodule

//--- verilog/lsuTop.sv
`timescale 1ns/100ps

module lsuTop (
  input logic clk,
  input logic rst,
  input logic opReq,
  output logic opAck,
  input logic opIsStore,
  input lsuPkg::addrT opAddr,
  input lsuPkg::wordT opWdata,
  input lsuPkg::byteMaskT opMask,
  output logic memReq,
  input logic memAck,
  output logic memWrite,
  output lsuPkg::addrT memAddr,
  output lsuPkg::wordT memWdata,
  input lsuPkg::wordT memRdata,
  output logic resValid,
  output lsuPkg::addrT resAddr,
  output lsuPkg::wordT resData
);

  opIf opBus ();
  lookupIf lookBus ();

  lsuDecode decode_i (
    .clk(clk),
    .rst(rst),
    .opReq(opReq),
    .opAck(opAck),
    .opIsStore(opIsStore),
    .opAddr(opAddr),
    .opWdata(opWdata),
    .opMask(opMask),
    .op(opBus.decodeSide)
  );

  lsuExecute execute_i (
    .clk(clk),
    .rst(rst),
    .op(opBus.executeSide),
    .look(lookBus.executeSide)
  );

  lsuResult result_i (
    .clk(clk),
    .rst(rst),
    .op(opBus.resultSide),
    .look(lookBus.resultSide),
    .memReq(memReq),
    .memAck(memAck),
    .memWrite(memWrite),
    .memAddr(memAddr),
    .memWdata(memWdata),
    .memRdata(memRdata),
    .resValid(resValid),
    .resAddr(resAddr),
    .resData(resData)
  );

endmodule
